// ==== src/dl1c_geom_pkg.sv ====
package dl1c_geom_pkg;

   // Cache organisation
   localparam int ways = 2;
   localparam int num_sets = 16;
   localparam int set_width = 4;

   // Line size, shared with the level-two cache
   localparam int line_bytes = 32;
   localparam int line_bits = line_bytes * 8;
   localparam int word_sel_width = 3;

   // Line address is tag plus set
   localparam int tag_width = 23;

   // Addresses keep their byte-address bit numbering
   typedef logic [31:2] word_addr_t;
   typedef logic [31:5] line_addr_t;

   typedef logic [tag_width-1:0]      tag_t;
   typedef logic [set_width-1:0]      set_t;
   typedef logic [word_sel_width-1:0] word_sel_t;
   typedef logic [line_bits-1:0]      line_t;
   typedef logic [3:0]                byte_en_t;

   typedef enum logic [2:0] {
      st_idle,
      st_fill_req,
      st_fill_wait,
      st_fill_write,
      st_write
   } ctrl_state_e;

endpackage

// ==== src/dl1c_ltc_pkg.sv ====
package dl1c_ltc_pkg;

   // Width of the level-two opcode field
   localparam int opcode_width = 3;

   // Requests understood by the level-two arbiter
   typedef enum logic [opcode_width-1:0] {
      ltc_opc_read  = 3'd0,
      ltc_opc_write = 3'd1
   } ltc_opcode_e;

   // One enable per byte of a transferred line
   typedef logic [dl1c_geom_pkg::line_bytes-1:0] line_be_t;

endpackage

// ==== src/dl1c_array_if.sv ====
`timescale 1ns/1ps

interface dl1c_array_if;

   // Lookup address, presented every cycle
   dl1c_geom_pkg::set_t  set;
   dl1c_geom_pkg::tag_t  lookup_tag;

   // Update strobes
   logic                 fill;
   logic                 write;
   logic                 touch;
   dl1c_geom_pkg::line_t wdata;

   // Lookup result for the set of the previous cycle
   logic                 hit;
   dl1c_geom_pkg::line_t rdata;

   modport ctrl_mp (
      output set, lookup_tag, fill, write, touch, wdata,
      input  hit, rdata
   );

   modport array_mp (
      input  set, lookup_tag, fill, write, touch, wdata,
      output hit, rdata
   );

endinterface

// ==== src/dl1c_way_ram.sv ====
`timescale 1ns/1ps

module dl1c_way_ram (
   input  logic         clkrst_mem_clk,
   input  logic [3:0]   set,
   input  logic         we,
   input  logic [255:0] wline,
   input  logic [22:0]  wtag,
   output logic [255:0] rline,
   output logic [22:0]  rtag
);

   logic [255:0] line_mem [16];
   logic [22:0]  tag_mem [16];

   // Write-first port, so a lookup right after a fill sees the new line
   always_ff @(posedge clkrst_mem_clk) begin
      if (we) begin
         line_mem[set] <= wline;
         tag_mem[set] <= wtag;
         rline <= wline;
         rtag <= wtag;
      end else begin
         rline <= line_mem[set];
         rtag <= tag_mem[set];
      end
   end

endmodule

// ==== src/dl1c_array.sv ====
`timescale 1ns/1ps

module dl1c_array (
   input  logic clkrst_mem_clk,
   input  logic clkrst_mem_rst_n,
   dl1c_array_if.array_mp arr
);

   // Per-way valid vectors and per-set victim way
   logic [dl1c_geom_pkg::num_sets-1:0] valid [dl1c_geom_pkg::ways];
   logic [dl1c_geom_pkg::num_sets-1:0] victim;

   // Lookup address, aligned with the RAM read data
   dl1c_geom_pkg::set_t set_q;
   dl1c_geom_pkg::tag_t tag_q;

   dl1c_geom_pkg::line_t rline [dl1c_geom_pkg::ways];
   dl1c_geom_pkg::tag_t  rtag [dl1c_geom_pkg::ways];

   logic [dl1c_geom_pkg::ways-1:0] way_we;
   logic [dl1c_geom_pkg::ways-1:0] way_hit;
   logic                           hit_way;
   logic                           fill_way;

   // With two ways the hitting index is simply whether way 1 hit
   assign hit_way = way_hit[1];
   assign fill_way = victim[arr.set];

   for (genvar w = 0; w < dl1c_geom_pkg::ways; w++) begin : g_way
      assign way_hit[w] = valid[w][set_q] && (rtag[w] == tag_q);

      // Fill goes to the victim, a write to the way that already holds the line
      assign way_we[w] = (arr.fill && (fill_way == 1'(w))) ||
                         (arr.write && (hit_way == 1'(w)));

      dl1c_way_ram u_ram (
         .clkrst_mem_clk (clkrst_mem_clk),
         .set            (arr.set),
         .we             (way_we[w]),
         .wline          (arr.wdata),
         .wtag           (arr.lookup_tag),
         .rline          (rline[w]),
         .rtag           (rtag[w])
      );
   end

   assign arr.hit = |way_hit;
   assign arr.rdata = rline[hit_way];

   always_ff @(posedge clkrst_mem_clk) begin
      set_q <= arr.set;
      tag_q <= arr.lookup_tag;
   end

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         for (int w = 0; w < dl1c_geom_pkg::ways; w++) begin
            valid[w] <= '0;
         end
         victim <= '0;
      end else begin
         if (arr.fill) begin
            valid[fill_way][arr.set] <= 1'b1;
         end
         // Other way of a hitting set becomes the next victim
         if (arr.touch) begin
            victim[set_q] <= ~hit_way;
         end
      end
   end

endmodule

// ==== src/dl1c_ctrl.sv ====
`timescale 1ns/1ps

module dl1c_ctrl (
   input  logic                      clkrst_mem_clk,
   input  logic                      clkrst_mem_rst_n,
   input  dl1c_geom_pkg::word_addr_t dl1c_addr,
   input  logic                      dl1c_re,
   input  dl1c_geom_pkg::byte_en_t   dl1c_we,
   input  logic [31:0]               dl1c_in,
   output logic [31:0]               dl1c_out,
   output logic                      dl1c_ready,
   output logic                      dl1c2arb_valid,
   output dl1c_ltc_pkg::ltc_opcode_e dl1c2arb_opcode,
   output dl1c_geom_pkg::line_addr_t dl1c2arb_addr,
   output dl1c_geom_pkg::line_t      dl1c2arb_wdata,
   output dl1c_ltc_pkg::line_be_t    dl1c2arb_wbe,
   input  dl1c_geom_pkg::line_t      dl1c2arb_rdata,
   input  logic                      dl1c2arb_rvalid,
   input  logic                      dl1c2arb_stall,
   dl1c_array_if.ctrl_mp             arr
);

   dl1c_geom_pkg::ctrl_state_e state;
   dl1c_geom_pkg::ctrl_state_e state_d;
   logic                       pend;

   // Latched request
   dl1c_geom_pkg::word_addr_t addr_q;
   logic                      re_q;
   dl1c_geom_pkg::byte_en_t   we_q;
   logic [31:0]               din_q;
   dl1c_geom_pkg::line_t      fill_q;

   dl1c_geom_pkg::word_addr_t cur_addr;
   dl1c_geom_pkg::word_sel_t  word_sel;
   logic [7:0]                bit_shift;
   logic [4:0]                be_shift;
   logic [31:0]               bit_mask;
   dl1c_geom_pkg::line_t      merged;
   dl1c_ltc_pkg::line_be_t    line_be;

   logic accept;
   logic is_write;
   logic lookup;
   logic lookup_done;
   logic do_write;
   logic issue_rd;
   logic req_done;
   logic fill_taken;

   assign dl1c_ready = (state == dl1c_geom_pkg::st_idle) && !pend;
   assign accept = dl1c_ready && (dl1c_re || (|dl1c_we));

   // Lookup cycle is idle with a request still pending
   assign is_write = |we_q;
   assign lookup = (state == dl1c_geom_pkg::st_idle) && pend;
   assign lookup_done = lookup && arr.hit && (!is_write || !dl1c2arb_stall);
   assign do_write = lookup_done && is_write;
   assign issue_rd = (state == dl1c_geom_pkg::st_fill_req) && !dl1c2arb_stall;
   assign fill_taken = (state == dl1c_geom_pkg::st_fill_wait) && dl1c2arb_rvalid &&
                       !dl1c2arb_stall;
   assign req_done = (lookup_done && !is_write) ||
                     ((state == dl1c_geom_pkg::st_write) && !dl1c2arb_stall);

   // Incoming address is looked up directly so a hit costs one cycle
   assign cur_addr = dl1c_ready ? dl1c_addr : addr_q;
   assign word_sel = addr_q[2 +: dl1c_geom_pkg::word_sel_width];
   assign bit_shift = {word_sel, 5'd0};
   assign be_shift = {word_sel, 2'd0};

   assign bit_mask = {{8{we_q[3]}}, {8{we_q[2]}}, {8{we_q[1]}}, {8{we_q[0]}}};
   assign merged = (arr.rdata & ~(dl1c_geom_pkg::line_t'(bit_mask) << bit_shift)) |
                   (dl1c_geom_pkg::line_t'(din_q & bit_mask) << bit_shift);
   assign line_be = dl1c_ltc_pkg::line_be_t'(we_q) << be_shift;

   assign arr.set = cur_addr[31 - dl1c_geom_pkg::tag_width -: dl1c_geom_pkg::set_width];
   assign arr.lookup_tag = cur_addr[31 -: dl1c_geom_pkg::tag_width];
   assign arr.fill = (state == dl1c_geom_pkg::st_fill_write);
   assign arr.write = do_write;
   assign arr.touch = lookup_done;
   assign arr.wdata = arr.fill ? fill_q : merged;

   always_comb begin
      state_d = state;
      unique case (state)
         dl1c_geom_pkg::st_idle: begin
            if (lookup && !arr.hit) begin
               state_d = dl1c_geom_pkg::st_fill_req;
            end else if (do_write) begin
               state_d = dl1c_geom_pkg::st_write;
            end
         end
         dl1c_geom_pkg::st_fill_req: begin
            if (!dl1c2arb_stall) begin
               state_d = dl1c_geom_pkg::st_fill_wait;
            end
         end
         dl1c_geom_pkg::st_fill_wait: begin
            if (fill_taken) begin
               state_d = dl1c_geom_pkg::st_fill_write;
            end
         end
         // Back to lookup, which now hits
         dl1c_geom_pkg::st_fill_write: state_d = dl1c_geom_pkg::st_idle;
         // Level-two write held here until it is taken
         dl1c_geom_pkg::st_write: begin
            if (!dl1c2arb_stall) begin
               state_d = dl1c_geom_pkg::st_idle;
            end
         end
         default: state_d = dl1c_geom_pkg::st_idle;
      endcase
   end

   always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         state <= dl1c_geom_pkg::st_idle;
         pend <= 1'b0;
         dl1c2arb_valid <= 1'b0;
      end else begin
         state <= state_d;
         if (accept) begin
            pend <= 1'b1;
         end else if (req_done) begin
            pend <= 1'b0;
         end
         if (!dl1c2arb_stall) begin
            dl1c2arb_valid <= issue_rd || do_write;
         end
      end
   end

   always_ff @(posedge clkrst_mem_clk) begin
      if (accept) begin
         addr_q <= dl1c_addr;
         re_q <= dl1c_re;
         we_q <= dl1c_we;
         din_q <= dl1c_in;
      end
      if (fill_taken) begin
         fill_q <= dl1c2arb_rdata;
      end
      // Read data holds until the next read completes
      if (lookup_done && re_q) begin
         dl1c_out <= arr.rdata[bit_shift +: 32];
      end
      if (issue_rd) begin
         dl1c2arb_opcode <= dl1c_ltc_pkg::ltc_opc_read;
         dl1c2arb_addr <= addr_q[31:5];
      end
      if (do_write) begin
         dl1c2arb_opcode <= dl1c_ltc_pkg::ltc_opc_write;
         dl1c2arb_addr <= addr_q[31:5];
         dl1c2arb_wdata <= merged;
         dl1c2arb_wbe <= line_be;
      end
   end

endmodule

// ==== src/dl1c_top.sv ====
`timescale 1ns/1ps

module dl1c_top (
   input  logic                      clkrst_mem_clk,
   input  logic                      clkrst_mem_rst_n,
   input  dl1c_geom_pkg::word_addr_t dl1c_addr,
   input  logic                      dl1c_re,
   input  dl1c_geom_pkg::byte_en_t   dl1c_we,
   input  logic [31:0]               dl1c_in,
   output logic [31:0]               dl1c_out,
   output logic                      dl1c_ready,
   output logic                      dl1c2arb_valid,
   output dl1c_ltc_pkg::ltc_opcode_e dl1c2arb_opcode,
   output dl1c_geom_pkg::line_addr_t dl1c2arb_addr,
   output dl1c_geom_pkg::line_t      dl1c2arb_wdata,
   output dl1c_ltc_pkg::line_be_t    dl1c2arb_wbe,
   input  dl1c_geom_pkg::line_t      dl1c2arb_rdata,
   input  logic                      dl1c2arb_rvalid,
   input  logic                      dl1c2arb_stall
);

   dl1c_array_if arr_if ();

   dl1c_ctrl u_ctrl (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .dl1c_addr        (dl1c_addr),
      .dl1c_re          (dl1c_re),
      .dl1c_we          (dl1c_we),
      .dl1c_in          (dl1c_in),
      .dl1c_out         (dl1c_out),
      .dl1c_ready       (dl1c_ready),
      .dl1c2arb_valid   (dl1c2arb_valid),
      .dl1c2arb_opcode  (dl1c2arb_opcode),
      .dl1c2arb_addr    (dl1c2arb_addr),
      .dl1c2arb_wdata   (dl1c2arb_wdata),
      .dl1c2arb_wbe     (dl1c2arb_wbe),
      .dl1c2arb_rdata   (dl1c2arb_rdata),
      .dl1c2arb_rvalid  (dl1c2arb_rvalid),
      .dl1c2arb_stall   (dl1c2arb_stall),
      .arr              (arr_if.ctrl_mp)
   );

   dl1c_array u_array (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .arr              (arr_if.array_mp)
   );

endmodule

// ==== verif/dl1c_l2_model.sv ====
`timescale 1ns/1ps

module dl1c_l2_model #(
   parameter logic [31:0] init_xor = 32'h0
) (
   input  logic                      clkrst_mem_clk,
   input  logic                      clkrst_mem_rst_n,
   input  logic                      stall_en,
   input  logic                      valid,
   input  dl1c_ltc_pkg::ltc_opcode_e opcode,
   input  dl1c_geom_pkg::line_addr_t addr,
   input  dl1c_geom_pkg::line_t      wdata,
   input  dl1c_ltc_pkg::line_be_t    wbe,
   output dl1c_geom_pkg::line_t      rdata,
   output logic                      rvalid,
   output logic                      stall
);

   // Sparse backing store where untouched words follow the init pattern
   logic [31:0] mem [logic [29:0]];
   integer seed;
   logic rd_pend;
   int rd_cnt;
   dl1c_geom_pkg::line_addr_t rd_addr;

   initial seed = 32'ha0f9_4e01;

   function automatic logic [31:0] word_at(input logic [29:0] wa);
      if (mem.exists(wa)) begin
         return mem[wa];
      end
      return {2'b00, wa} ^ init_xor;
   endfunction

   function automatic dl1c_geom_pkg::line_t line_at(input dl1c_geom_pkg::line_addr_t la);
      dl1c_geom_pkg::line_t l;
      for (int i = 0; i < 8; i++) begin
         l[i*32 +: 32] = word_at({la, 3'(i)});
      end
      return l;
   endfunction

   task automatic write_line(input dl1c_geom_pkg::line_addr_t la,
                             input dl1c_geom_pkg::line_t d,
                             input dl1c_ltc_pkg::line_be_t be);
      logic [29:0] wa;
      logic [31:0] w;
      for (int i = 0; i < 8; i++) begin
         wa = {la, 3'(i)};
         w = word_at(wa);
         for (int b = 0; b < 4; b++) begin
            if (be[i*4 + b]) begin
               w[b*8 +: 8] = d[i*32 + b*8 +: 8];
            end
         end
         mem[wa] = w;
      end
   endtask

   always @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
      if (!clkrst_mem_rst_n) begin
         rdata <= '0;
         rvalid <= 1'b0;
         stall <= 1'b0;
         rd_pend <= 1'b0;
         rd_cnt <= 0;
      end else begin
         // Read data held until taken in an unstalled cycle
         if (rvalid && !stall) begin
            rvalid <= 1'b0;
         end
         if (valid && !stall) begin
            if (opcode == dl1c_ltc_pkg::ltc_opc_read) begin
               rd_pend <= 1'b1;
               rd_addr <= addr;
               rd_cnt <= 1 + int'($unsigned($random(seed)) % 4);
            end else begin
               write_line(addr, wdata, wbe);
            end
         end
         if (rd_pend) begin
            if (rd_cnt == 0) begin
               rdata <= line_at(rd_addr);
               rvalid <= 1'b1;
               rd_pend <= 1'b0;
            end else begin
               rd_cnt <= rd_cnt - 1;
            end
         end
         stall <= stall_en && (($random(seed) & 3) == 0);
      end
   end

endmodule

// ==== verif/dl1c_chk.sv ====
`timescale 1ns/1ps

module dl1c_chk (
   input logic                      clkrst_mem_clk,
   input logic                      clkrst_mem_rst_n,
   input logic                      valid,
   input logic                      ready,
   input logic                      stall,
   input dl1c_ltc_pkg::ltc_opcode_e opcode,
   input dl1c_geom_pkg::line_addr_t addr,
   input dl1c_geom_pkg::line_t      wdata,
   input dl1c_ltc_pkg::line_be_t    wbe
);

   a_valid_in_reset: assert property (@(posedge clkrst_mem_clk)
      !clkrst_mem_rst_n |-> !valid)
      else $error("level-two valid high during reset");

   // A stalled request must not move
   a_stall_hold: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      (valid && stall) |=> (valid && $stable(opcode) && $stable(addr) &&
                            $stable(wdata) && $stable(wbe)))
      else $error("level-two request changed under stall");

   a_busy_while_valid: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
      valid |-> !ready)
      else $error("ready high while a level-two request is valid");

endmodule

bind dl1c_ctrl dl1c_chk u_chk (
   .clkrst_mem_clk   (clkrst_mem_clk),
   .clkrst_mem_rst_n (clkrst_mem_rst_n),
   .valid            (dl1c2arb_valid),
   .ready            (dl1c_ready),
   .stall            (dl1c2arb_stall),
   .opcode           (dl1c2arb_opcode),
   .addr             (dl1c2arb_addr),
   .wdata            (dl1c2arb_wdata),
   .wbe              (dl1c2arb_wbe)
);

// ==== verif/dl1c_tb.sv ====
`timescale 1ns/1ps

module dl1c_tb;

   localparam logic [31:0] init_xor = 32'h5a3c_96e1;
   // About 50 accesses at under 40 cycles each, with plenty of margin
   localparam int max_cycles = 4000;

   logic clkrst_mem_clk;
   logic clkrst_mem_rst_n;
   dl1c_geom_pkg::word_addr_t dl1c_addr;
   logic dl1c_re;
   dl1c_geom_pkg::byte_en_t dl1c_we;
   logic [31:0] dl1c_in;
   logic [31:0] dl1c_out;
   logic dl1c_ready;
   logic dl1c2arb_valid;
   dl1c_ltc_pkg::ltc_opcode_e dl1c2arb_opcode;
   dl1c_geom_pkg::line_addr_t dl1c2arb_addr;
   dl1c_geom_pkg::line_t dl1c2arb_wdata;
   dl1c_ltc_pkg::line_be_t dl1c2arb_wbe;
   dl1c_geom_pkg::line_t dl1c2arb_rdata;
   logic dl1c2arb_rvalid;
   logic dl1c2arb_stall;
   logic stall_en;

   integer seed;
   int errors;
   int checks;
   int tests;
   int cycle_count;
   int rd_count;
   int wr_count;
   dl1c_geom_pkg::line_addr_t last_rd_addr;
   dl1c_geom_pkg::line_addr_t last_wr_addr;
   dl1c_geom_pkg::line_t last_wdata;
   dl1c_ltc_pkg::line_be_t last_wbe;

   // Expected memory contents
   logic [31:0] sb_mem [logic [29:0]];

   dl1c_top uut (.*);

   dl1c_l2_model #(.init_xor(init_xor)) u_l2 (
      .clkrst_mem_clk   (clkrst_mem_clk),
      .clkrst_mem_rst_n (clkrst_mem_rst_n),
      .stall_en         (stall_en),
      .valid            (dl1c2arb_valid),
      .opcode           (dl1c2arb_opcode),
      .addr             (dl1c2arb_addr),
      .wdata            (dl1c2arb_wdata),
      .wbe              (dl1c2arb_wbe),
      .rdata            (dl1c2arb_rdata),
      .rvalid           (dl1c2arb_rvalid),
      .stall            (dl1c2arb_stall)
   );

   initial begin
      clkrst_mem_clk = 1'b0;
      forever #4 clkrst_mem_clk = ~clkrst_mem_clk;
   end

   always @(posedge clkrst_mem_clk) begin
      cycle_count <= cycle_count + 1;
   end

   // Level-two requests taken in unstalled cycles
   always @(posedge clkrst_mem_clk) begin
      if (clkrst_mem_rst_n && dl1c2arb_valid && !dl1c2arb_stall) begin
         if (dl1c2arb_opcode == dl1c_ltc_pkg::ltc_opc_read) begin
            rd_count = rd_count + 1;
            last_rd_addr = dl1c2arb_addr;
         end else begin
            wr_count = wr_count + 1;
            last_wr_addr = dl1c2arb_addr;
            last_wdata = dl1c2arb_wdata;
            last_wbe = dl1c2arb_wbe;
         end
      end
   end

   initial begin
      while (cycle_count < max_cycles) begin
         @(posedge clkrst_mem_clk);
      end
      $display("Timeout after %0d cycles, the DUT stopped responding", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic logic [31:0] sb_read(input logic [29:0] wa);
      if (sb_mem.exists(wa)) begin
         return sb_mem[wa];
      end
      return {2'b00, wa} ^ init_xor;
   endfunction

   task automatic sb_write(input logic [29:0] wa, input logic [3:0] we, input logic [31:0] d);
      logic [31:0] w;
      w = sb_read(wa);
      for (int b = 0; b < 4; b++) begin
         if (we[b]) begin
            w[b*8 +: 8] = d[b*8 +: 8];
         end
      end
      sb_mem[wa] = w;
   endtask

   task automatic check_val(input string msg, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
   endtask

   // One request, waits for ready to return
   task automatic access(input logic [31:0] baddr, input logic re, input logic [3:0] we,
                         input logic [31:0] din, output logic [31:0] rd, output int cycles);
      while (!dl1c_ready) begin
         @(posedge clkrst_mem_clk);
         #1;
      end
      dl1c_addr = baddr[31:2];
      dl1c_re = re;
      dl1c_we = we;
      dl1c_in = din;
      @(posedge clkrst_mem_clk);
      #1;
      dl1c_re = 1'b0;
      dl1c_we = 4'h0;
      cycles = 0;
      do begin
         @(posedge clkrst_mem_clk);
         #1;
         cycles++;
      end while (!dl1c_ready);
      rd = dl1c_out;
   endtask

   task automatic test_reset();
      int e0;
      e0 = errors;
      check_val("ready after reset", 32'(dl1c_ready), 32'd1);
      check_val("valid after reset", 32'(dl1c2arb_valid), 32'd0);
      finish_test("reset", e0);
   endtask

   task automatic test_read_miss_hit();
      int e0;
      int r0;
      int cyc;
      logic [31:0] rd;
      e0 = errors;
      r0 = rd_count;
      access(32'h0000_1024, 1'b1, 4'h0, 32'h0, rd, cyc);
      check_val("miss read requests", 32'(rd_count - r0), 32'd1);
      check_val("miss read line address", 32'(last_rd_addr), 32'h0000_1024 >> 5);
      check_val("miss read data", rd, sb_read(30'h0000_1024 >> 2));
      access(32'h0000_1038, 1'b1, 4'h0, 32'h0, rd, cyc);
      check_val("hit read requests", 32'(rd_count - r0), 32'd1);
      check_val("hit read latency", 32'(cyc), 32'd1);
      check_val("hit read data", rd, sb_read(30'h0000_1038 >> 2));
      finish_test("read miss then hit", e0);
   endtask

   task automatic test_masked_write();
      int e0;
      int w0;
      int cyc;
      logic [31:0] rd;
      logic [31:0] baddr;
      dl1c_ltc_pkg::line_be_t exp_be;
      e0 = errors;
      w0 = wr_count;
      baddr = 32'h0000_2048;
      access(baddr, 1'b0, 4'b0110, 32'hdead_beef, rd, cyc);
      sb_write(baddr[31:2], 4'b0110, 32'hdead_beef);
      exp_be = '0;
      exp_be[int'(baddr[4:2])*4 +: 4] = 4'b0110;
      check_val("write requests", 32'(wr_count - w0), 32'd1);
      check_val("write line address", 32'(last_wr_addr), baddr >> 5);
      check_val("write byte enables", last_wbe, exp_be);
      for (int i = 0; i < 8; i++) begin
         check_val("write line data", last_wdata[i*32 +: 32], sb_read({baddr[31:5], 3'(i)}));
      end
      access(baddr, 1'b1, 4'h0, 32'h0, rd, cyc);
      check_val("merged read data", rd, sb_read(baddr[31:2]));
      finish_test("byte-masked write", e0);
   endtask

   task automatic test_victim();
      int e0;
      int r0;
      int cyc;
      logic [31:0] rd;
      e0 = errors;
      r0 = rd_count;
      // Three tags in set 5
      access(32'h0001_00a0, 1'b1, 4'h0, 32'h0, rd, cyc);
      access(32'h0002_00a0, 1'b1, 4'h0, 32'h0, rd, cyc);
      access(32'h0001_00a0, 1'b1, 4'h0, 32'h0, rd, cyc);
      access(32'h0003_00a0, 1'b1, 4'h0, 32'h0, rd, cyc);
      check_val("reads for A B A C", 32'(rd_count - r0), 32'd3);
      r0 = rd_count;
      access(32'h0001_00a0, 1'b1, 4'h0, 32'h0, rd, cyc);
      check_val("A still cached", 32'(rd_count - r0), 32'd0);
      check_val("A data", rd, sb_read(30'h0001_00a0 >> 2));
      access(32'h0002_00a0, 1'b1, 4'h0, 32'h0, rd, cyc);
      check_val("B evicted", 32'(rd_count - r0), 32'd1);
      check_val("B data", rd, sb_read(30'h0002_00a0 >> 2));
      finish_test("victim replacement", e0);
   endtask

   task automatic test_backpressure();
      int e0;
      int cyc;
      logic [31:0] r;
      logic [31:0] baddr;
      logic [31:0] din;
      logic [31:0] rd;
      logic [3:0] we;
      e0 = errors;
      stall_en = 1'b1;
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         baddr = 32'h0004_0000 | (r & 32'h0000_07fc);
         if (r[12]) begin
            we = r[19:16];
            if (we == 4'h0) begin
               we = 4'hf;
            end
            din = $random(seed);
            access(baddr, 1'b0, we, din, rd, cyc);
            sb_write(baddr[31:2], we, din);
         end else begin
            access(baddr, 1'b1, 4'h0, 32'h0, rd, cyc);
            check_val("random read data", rd, sb_read(baddr[31:2]));
         end
      end
      stall_en = 1'b0;
      finish_test("back-pressure", e0);
   endtask

   initial begin
      seed = 32'ha0f9_4e01;
      errors = 0;
      checks = 0;
      tests = 0;
      cycle_count = 0;
      rd_count = 0;
      wr_count = 0;
      stall_en = 1'b0;
      clkrst_mem_rst_n = 1'b0;
      dl1c_addr = '0;
      dl1c_re = 1'b0;
      dl1c_we = 4'h0;
      dl1c_in = 32'h0;
      repeat (5) @(posedge clkrst_mem_clk);
      #1;
      clkrst_mem_rst_n = 1'b1;
      @(posedge clkrst_mem_clk);
      #1;
      test_reset();
      test_read_miss_hit();
      test_masked_write();
      test_victim();
      test_backpressure();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== dl1c.f ====
src/dl1c_geom_pkg.sv
src/dl1c_ltc_pkg.sv
src/dl1c_array_if.sv
src/dl1c_way_ram.sv
src/dl1c_array.sv
src/dl1c_ctrl.sv
src/dl1c_top.sv
verif/dl1c_l2_model.sv
verif/dl1c_chk.sv
verif/dl1c_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dl1c_tb -f dl1c.f -o dl1c_sim
	./obj_dir/dl1c_sim | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
